// ==== dma_addr_cfg.svh ====
// -------------------------------------------------------------------------
// DMA address generator widths and depths
// -------------------------------------------------------------------------

`ifndef DMA_ADDR_CFG_SVH
`define DMA_ADDR_CFG_SVH

// byte address width of the AXI address channel
`define DMA_ADDR_WIDTH 32

// log2 of bytes per beat (0:8bit, 1:16bit, 2:32bit ...)
`define DMA_DATA_SIZE 2

// AXI4 len field
`define DMA_LEN_WIDTH 8

// beat count covers the whole address space in beats
`define DMA_COUNT_WIDTH (`DMA_ADDR_WIDTH - `DMA_DATA_SIZE)

// length queue toward the data mover, power of two
`define DMA_CMD_FIFO_DEPTH 4

`endif

// ==== dma_addr_pkg.sv ====
// -------------------------------------------------------------------------
// DMA address generator types
// -------------------------------------------------------------------------

`default_nettype none

`include "dma_addr_cfg.svh"

package dma_addr_pkg;

	// byte address
	typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;

	// AXI burst length minus one
	typedef logic [`DMA_LEN_WIDTH-1:0] len_t;

	// beat count
	typedef logic [`DMA_COUNT_WIDTH-1:0] count_t;

	// one burst as held in the output slice
	typedef struct packed {
		addr_t addr;
		len_t  len;
	} burst_t;

endpackage

`default_nettype wire

// ==== burst_if.sv ====
// -------------------------------------------------------------------------
// Burst handoff, splitter to issue side
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

interface burst_if;

	// burst start address and len
	dma_addr_pkg::addr_t addr;
	dma_addr_pkg::len_t  len;

	// handshake, a burst moves when both are high
	logic valid;
	logic ready;

	modport split (
		output addr,
		output len,
		output valid,
		input  ready
	);

	modport issue (
		input  addr,
		input  len,
		input  valid,
		output ready
	);

endinterface

`default_nettype wire

// ==== dma_param_latch.sv ====
// -------------------------------------------------------------------------
// Transfer parameter capture
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module dma_param_latch (
	input  wire                  aclk,
	input  wire                  aresetn,
	input  wire                  start,
	input  dma_addr_pkg::addr_t  param_addr,
	input  dma_addr_pkg::count_t param_count,
	input  dma_addr_pkg::len_t   param_maxlen,
	input  wire                  split_busy,
	output logic                 enable,
	output dma_addr_pkg::addr_t  hold_addr,
	output dma_addr_pkg::count_t hold_count,
	output dma_addr_pkg::len_t   hold_maxlen,
	output logic                 busy,
	output logic                 done
);

	logic split_busy_d;
	logic accept;

	// start is only taken when idle
	assign accept = start && !busy;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy         <= 1'b0;
			enable       <= 1'b0;
			done         <= 1'b0;
			split_busy_d <= 1'b0;
		end else begin
			split_busy_d <= split_busy;
			enable       <= accept;
			// falling edge of the splitter busy ends the transfer
			done         <= split_busy_d && !split_busy;
			if (accept) begin
				busy <= 1'b1;
			end else if (split_busy_d && !split_busy) begin
				busy <= 1'b0;
			end
		end
	end

	// held for the whole transfer
	always_ff @(posedge aclk) begin
		if (accept) begin
			hold_addr   <= param_addr;
			hold_count  <= param_count;
			hold_maxlen <= param_maxlen;
		end
	end

	// a zero count would wrap the splitter's remaining count
	a_start_count: assert property (@(posedge aclk) disable iff (!aresetn)
		accept |-> (param_count != '0));

endmodule

`default_nettype wire

// ==== dma_burst_split.sv ====
// -------------------------------------------------------------------------
// Burst splitter with 4 KB boundary limit
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "dma_addr_cfg.svh"

module dma_burst_split (
	input  wire                  aclk,
	input  wire                  aresetn,
	input  wire                  enable,
	input  dma_addr_pkg::addr_t  param_addr,
	input  dma_addr_pkg::count_t param_count,
	input  dma_addr_pkg::len_t   param_maxlen,
	output logic                 busy,
	burst_if.split               out
);

	localparam int ADDR_W    = `DMA_ADDR_WIDTH;
	localparam int DATA_SIZE = `DMA_DATA_SIZE;
	localparam int LEN_W     = `DMA_LEN_WIDTH;
	localparam int COUNT_W   = `DMA_COUNT_WIDTH;
	// beats inside one 4 KB page
	localparam int ROOM_W    = 12 - DATA_SIZE;
	localparam int SUM_W     = ROOM_W + 1;

	// room to the page end, clipped to the maximum length
	function automatic logic [ROOM_W-1:0] clip_room(
		input logic [ROOM_W-1:0] room,
		input dma_addr_pkg::len_t maxlen
	);
		logic [ROOM_W-1:0] wide_max;
		wide_max  = ROOM_W'(maxlen);
		clip_room = (room < wide_max) ? room : wide_max;
	endfunction

	logic                 cke;
	logic                 single_q;
	logic                 setup_q;
	logic                 valid_q;
	logic [COUNT_W-1:0]   beat_addr_q;
	dma_addr_pkg::len_t   len_q;
	// remaining beats minus one
	dma_addr_pkg::count_t count_q;
	logic [ROOM_W-1:0]    room_q;

	logic [COUNT_W-1:0]   next_addr;
	dma_addr_pkg::count_t next_count;
	logic [ROOM_W-1:0]    next_room;
	dma_addr_pkg::len_t   setup_len;
	logic                 last_burst;

	// stall while a burst waits on the output
	assign cke = !valid_q || out.ready;

	assign next_count = count_q - dma_addr_pkg::count_t'(len_q) - 1'b1;
	assign next_addr  = beat_addr_q + COUNT_W'(len_q) + 1'b1;
	assign next_room  = ~next_addr[ROOM_W-1:0];
	assign last_burst = (count_q == dma_addr_pkg::count_t'(len_q));

	// room_q is already at most maxlen, so the low bits carry it
	assign setup_len = (count_q < dma_addr_pkg::count_t'(room_q)) ?
		count_q[LEN_W-1:0] : room_q[LEN_W-1:0];

	// -------------------------------------------------------------------------
	// control
	// -------------------------------------------------------------------------

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy     <= 1'b0;
			single_q <= 1'b0;
			setup_q  <= 1'b0;
			valid_q  <= 1'b0;
		end else if (cke) begin
			if (!busy) begin
				if (enable) begin
					busy     <= 1'b1;
					// maxlen zero goes straight to single beats
					single_q <= (param_maxlen == '0);
					setup_q  <= (param_maxlen != '0);
					valid_q  <= (param_maxlen == '0);
				end
			end else if (setup_q) begin
				setup_q <= 1'b0;
				valid_q <= 1'b1;
			end else if (last_burst) begin
				busy     <= 1'b0;
				single_q <= 1'b0;
				valid_q  <= 1'b0;
			end else begin
				setup_q <= !single_q;
				valid_q <= single_q;
			end
		end
	end

	// -------------------------------------------------------------------------
	// address, count and length
	// -------------------------------------------------------------------------

	always_ff @(posedge aclk) begin
		if (cke) begin
			if (!busy) begin
				beat_addr_q <= param_addr[ADDR_W-1:DATA_SIZE];
				len_q       <= '0;
				count_q     <= param_count - 1'b1;
				room_q      <= clip_room(~param_addr[11:DATA_SIZE], param_maxlen);
			end else if (setup_q) begin
				len_q <= setup_len;
			end else if (!last_burst) begin
				// step past the accepted burst
				beat_addr_q <= next_addr;
				count_q     <= next_count;
				len_q       <= '0;
				room_q      <= clip_room(next_room, param_maxlen);
			end
		end
	end

	assign out.addr  = {beat_addr_q, {DATA_SIZE{1'b0}}};
	assign out.len   = len_q;
	assign out.valid = valid_q;

	a_valid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		(out.valid && !out.ready) |=>
			(out.valid && $stable(out.addr) && $stable(out.len)));

	// last beat stays inside the page of the first
	a_no_4k_cross: assert property (@(posedge aclk) disable iff (!aresetn)
		out.valid |->
			((SUM_W'(out.addr[11:DATA_SIZE]) + SUM_W'(out.len)) < SUM_W'(1 << ROOM_W)));

endmodule

`default_nettype wire

// ==== dma_cmd_issue.sv ====
// -------------------------------------------------------------------------
// AXI address slice and length queue
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "dma_addr_cfg.svh"

module dma_cmd_issue (
	input  wire                 aclk,
	input  wire                 aresetn,
	burst_if.issue              in,
	output dma_addr_pkg::addr_t ar_addr,
	output dma_addr_pkg::len_t  ar_len,
	output logic                ar_valid,
	input  wire                 ar_ready,
	output dma_addr_pkg::len_t  cmd_len,
	output logic                cmd_valid,
	input  wire                 cmd_ready
);

	localparam int DEPTH  = `DMA_CMD_FIFO_DEPTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int FILL_W = PTR_W + 1;

	dma_addr_pkg::burst_t slice_q;
	dma_addr_pkg::len_t   fifo_mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr_q;
	logic [PTR_W-1:0]     rd_ptr_q;
	logic [FILL_W-1:0]    fill_q;
	logic                 fifo_full;
	logic                 push;
	logic                 pop;

	assign fifo_full = (fill_q == FILL_W'(DEPTH));
	// slice empty or draining, and room in the queue
	assign in.ready  = (!ar_valid || ar_ready) && !fifo_full;
	assign push      = in.valid && in.ready;
	assign pop       = cmd_valid && cmd_ready;

	// -------------------------------------------------------------------------
	// address channel slice
	// -------------------------------------------------------------------------

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			ar_valid <= 1'b0;
		end else if (push) begin
			ar_valid <= 1'b1;
		end else if (ar_ready) begin
			ar_valid <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (push) begin
			slice_q <= '{addr: in.addr, len: in.len};
		end
	end

	assign ar_addr = slice_q.addr;
	assign ar_len  = slice_q.len;

	// -------------------------------------------------------------------------
	// length queue with pointers wrapping at the power of two depth
	// -------------------------------------------------------------------------

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			fill_q   <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   fill_q <= fill_q + 1'b1;
				2'b01:   fill_q <= fill_q - 1'b1;
				default: fill_q <= fill_q;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (push) begin
			fifo_mem[wr_ptr_q] <= in.len;
		end
	end

	assign cmd_len   = fifo_mem[rd_ptr_q];
	assign cmd_valid = (fill_q != '0);

	// occupancy never passes the depth and agrees with the pointers
	a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
		(fill_q <= FILL_W'(DEPTH)) && ((wr_ptr_q - rd_ptr_q) == PTR_W'(fill_q)));

	a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		(ar_valid && !ar_ready) |=>
			(ar_valid && $stable(ar_addr) && $stable(ar_len)));

endmodule

`default_nettype wire

// ==== dma_addr_top.sv ====
// -------------------------------------------------------------------------
// DMA address command generator
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module dma_addr_top (
	input  wire                  aclk,
	input  wire                  aresetn,
	input  wire                  start,
	input  dma_addr_pkg::addr_t  param_addr,
	input  dma_addr_pkg::count_t param_count,
	input  dma_addr_pkg::len_t   param_maxlen,
	output logic                 busy,
	output logic                 done,
	output dma_addr_pkg::addr_t  ar_addr,
	output dma_addr_pkg::len_t   ar_len,
	output logic                 ar_valid,
	input  wire                  ar_ready,
	output dma_addr_pkg::len_t   cmd_len,
	output logic                 cmd_valid,
	input  wire                  cmd_ready
);

	logic                 enable;
	logic                 split_busy;
	dma_addr_pkg::addr_t  hold_addr;
	dma_addr_pkg::count_t hold_count;
	dma_addr_pkg::len_t   hold_maxlen;

	burst_if burst ();

	dma_param_latch u_latch (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.start        (start),
		.param_addr   (param_addr),
		.param_count  (param_count),
		.param_maxlen (param_maxlen),
		.split_busy   (split_busy),
		.enable       (enable),
		.hold_addr    (hold_addr),
		.hold_count   (hold_count),
		.hold_maxlen  (hold_maxlen),
		.busy         (busy),
		.done         (done)
	);

	dma_burst_split u_split (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.enable       (enable),
		.param_addr   (hold_addr),
		.param_count  (hold_count),
		.param_maxlen (hold_maxlen),
		.busy         (split_busy),
		.out          (burst.split)
	);

	dma_cmd_issue u_issue (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.in        (burst.issue),
		.ar_addr   (ar_addr),
		.ar_len    (ar_len),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.cmd_len   (cmd_len),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready)
	);

endmodule

`default_nettype wire

// ==== tb_dma_checker.sv ====
// -------------------------------------------------------------------------
// DMA address generator burst checker
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "dma_addr_cfg.svh"

module tb_dma_checker (
	input  wire                 aclk,
	input  wire                 busy,
	input  wire                 done,
	input  dma_addr_pkg::addr_t ar_addr,
	input  dma_addr_pkg::len_t  ar_len,
	input  wire                 ar_valid,
	input  wire                 ar_ready,
	input  dma_addr_pkg::len_t  cmd_len,
	input  wire                 cmd_valid,
	input  wire                 cmd_ready
);

	localparam int DSIZE      = `DMA_DATA_SIZE;
	localparam int PAGE_BEATS = 4096 >> DSIZE;

	// handshakes seen on the DUT ports in order
	dma_addr_pkg::addr_t ar_addr_log [$];
	dma_addr_pkg::len_t  ar_len_log [$];
	dma_addr_pkg::len_t  cmd_len_log [$];

	// bursts predicted for the running test
	dma_addr_pkg::addr_t exp_addr_q [$];
	dma_addr_pkg::len_t  exp_len_q [$];

	string               test_name = "setup";
	dma_addr_pkg::addr_t test_addr;
	dma_addr_pkg::len_t  test_maxlen;
	int                  test_count;
	int                  test_total;
	int                  ar_base;
	int                  cmd_base;
	int                  done_count = 0;
	logic                busy_seen = 1'b0;
	logic                busy_last = 1'b0;
	int                  test_errors = 0;
	int                  errors = 0;
	int                  tests_run = 0;
	int                  tests_failed = 0;

	// transfer happens at the next rising edge
	always @(negedge aclk) begin
		if (ar_valid && ar_ready) begin
			ar_addr_log.push_back(ar_addr);
			ar_len_log.push_back(ar_len);
		end
		if (cmd_valid && cmd_ready) begin
			cmd_len_log.push_back(cmd_len);
		end
		if (busy) begin
			busy_seen = 1'b1;
		end
		// busy drops on the same edge that raises done
		if (done) begin
			done_count++;
			if (busy) begin
				report_problem("busy still high when done pulsed");
			end
		end else if (busy_last && !busy) begin
			report_problem("busy fell without a done pulse");
		end
		busy_last = busy;
	end

	task automatic report_problem(input string msg);
		$display("ERROR %s: %s", test_name, msg);
		test_errors++;
		errors++;
	endtask

	task automatic compare_hex(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s %s expected 0x%0h actual 0x%0h",
				test_name, what, expected, actual);
			test_errors++;
			errors++;
		end
	endtask

	task automatic compare_num(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("MISMATCH %s %s expected %0d actual %0d",
				test_name, what, expected, actual);
			test_errors++;
			errors++;
		end
	endtask

	// bursts stop at the page end, the remaining count or maxlen + 1 beats
	task automatic begin_test(input string name, input dma_addr_pkg::addr_t addr,
			input dma_addr_pkg::count_t count, input dma_addr_pkg::len_t maxlen,
			input int total);
		dma_addr_pkg::addr_t a;
		int rem;
		int room;
		int beats;
		test_name   = name;
		test_addr   = addr;
		test_count  = int'(count);
		test_maxlen = maxlen;
		test_total  = total;
		test_errors = 0;
		done_count  = 0;
		busy_seen   = 1'b0;
		ar_base     = ar_addr_log.size();
		cmd_base    = cmd_len_log.size();
		exp_addr_q.delete();
		exp_len_q.delete();
		a   = addr;
		rem = int'(count);
		while (rem > 0) begin
			room  = PAGE_BEATS - int'(a[11:DSIZE]);
			beats = rem;
			if (room < beats) begin
				beats = room;
			end
			if (int'(maxlen) + 1 < beats) begin
				beats = int'(maxlen) + 1;
			end
			exp_addr_q.push_back(a);
			exp_len_q.push_back(dma_addr_pkg::len_t'(beats - 1));
			a   = a + dma_addr_pkg::addr_t'(beats << DSIZE);
			rem = rem - beats;
		end
		if (exp_addr_q.size() != total) begin
			report_problem("trace burst total disagrees with the split rule");
		end
	endtask

	task automatic end_test();
		int                  i;
		int                  n_ar;
		int                  n_cmd;
		int                  beat_sum;
		int                  page_end;
		dma_addr_pkg::addr_t next_addr;
		dma_addr_pkg::addr_t got_addr;
		dma_addr_pkg::len_t  got_len;
		n_ar      = ar_addr_log.size() - ar_base;
		n_cmd     = cmd_len_log.size() - cmd_base;
		beat_sum  = 0;
		next_addr = test_addr;
		for (i = 0; i < n_ar; i++) begin
			got_addr = ar_addr_log[ar_base + i];
			got_len  = ar_len_log[ar_base + i];
			if (i < exp_addr_q.size()) begin
				compare_hex($sformatf("burst %0d ar_addr", i), exp_addr_q[i], got_addr);
				compare_hex($sformatf("burst %0d ar_len", i), 32'(exp_len_q[i]), 32'(got_len));
			end
			// each burst picks up where the last one stopped
			compare_hex($sformatf("burst %0d start", i), next_addr, got_addr);
			page_end = int'(got_addr[11:0]) + ((int'(got_len) + 1) << DSIZE);
			if (page_end > 4096) begin
				report_problem($sformatf("burst %0d crosses a 4 KB boundary", i));
			end
			if (got_len > test_maxlen) begin
				report_problem($sformatf("burst %0d is longer than the maximum length", i));
			end
			beat_sum  = beat_sum + int'(got_len) + 1;
			next_addr = got_addr + dma_addr_pkg::addr_t'((int'(got_len) + 1) << DSIZE);
		end
		compare_num("burst total", test_total, n_ar);
		compare_num("beat total", test_count, beat_sum);
		compare_num("length queue entries", n_ar, n_cmd);
		for (i = 0; i < n_ar && i < n_cmd; i++) begin
			compare_hex($sformatf("cmd_len %0d", i), 32'(ar_len_log[ar_base + i]),
				32'(cmd_len_log[cmd_base + i]));
		end
		// one transfer per test, a start while busy adds none
		compare_num("done pulses", 1, done_count);
		if (!busy_seen) begin
			report_problem("busy never went high during the transfer");
		end
		tests_run++;
		if (test_errors == 0) begin
			$display("PASS %s: %0d bursts, %0d beats", test_name, n_ar, beat_sum);
		end else begin
			tests_failed++;
			$display("FAIL %s: %0d errors", test_name, test_errors);
		end
	endtask

	task automatic print_summary();
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
	endtask

	function automatic int total_errors();
		return errors;
	endfunction

endmodule

`default_nettype wire

// ==== tb_dma_addr.sv ====
// -------------------------------------------------------------------------
// DMA address generator testbench
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_dma_addr;

	localparam int CLK_PERIOD     = 20;
	localparam int TIMEOUT_CYCLES = 2000;

	logic                 aclk = 1'b0;
	logic                 aresetn;
	logic                 start;
	dma_addr_pkg::addr_t  param_addr;
	dma_addr_pkg::count_t param_count;
	dma_addr_pkg::len_t   param_maxlen;
	logic                 busy;
	logic                 done;
	dma_addr_pkg::addr_t  ar_addr;
	dma_addr_pkg::len_t   ar_len;
	logic                 ar_valid;
	logic                 ar_ready;
	dma_addr_pkg::len_t   cmd_len;
	logic                 cmd_valid;
	logic                 cmd_ready;
	integer               seed = 32'h60a3;
	logic                 aborted = 1'b0;

	always #(CLK_PERIOD / 2) aclk = ~aclk;

	dma_addr_top uut (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.start        (start),
		.param_addr   (param_addr),
		.param_count  (param_count),
		.param_maxlen (param_maxlen),
		.busy         (busy),
		.done         (done),
		.ar_addr      (ar_addr),
		.ar_len       (ar_len),
		.ar_valid     (ar_valid),
		.ar_ready     (ar_ready),
		.cmd_len      (cmd_len),
		.cmd_valid    (cmd_valid),
		.cmd_ready    (cmd_ready)
	);

	tb_dma_checker u_check (
		.aclk      (aclk),
		.busy      (busy),
		.done      (done),
		.ar_addr   (ar_addr),
		.ar_len    (ar_len),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.cmd_len   (cmd_len),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready)
	);

	// random back-pressure with ar_ready mostly high and cmd_ready half the time
	initial begin : ready_gen
		logic [31:0] rnd;
		ar_ready  <= 1'b0;
		cmd_ready <= 1'b0;
		forever begin
			@(posedge aclk);
			rnd = $random(seed);
			ar_ready  <= (rnd[1:0] != 2'b00);
			cmd_ready <= rnd[4];
		end
	end

	task automatic run_transfer(input string name, input dma_addr_pkg::addr_t addr,
			input dma_addr_pkg::count_t count, input dma_addr_pkg::len_t maxlen,
			input int total);
		int cycles;
		@(posedge aclk);
		u_check.begin_test(name, addr, count, maxlen, total);
		start        <= 1'b1;
		param_addr   <= addr;
		param_count  <= count;
		param_maxlen <= maxlen;
		// second start cycle lands while busy with other parameters
		@(posedge aclk);
		param_addr  <= addr ^ 32'h0000_0840;
		param_count <= count + 30'd5;
		@(posedge aclk);
		start <= 1'b0;
		cycles = 0;
		do begin
			@(negedge aclk);
			cycles++;
		end while (!done && cycles < TIMEOUT_CYCLES);
		if (!done) begin
			u_check.report_problem("transfer did not finish");
			aborted = 1'b1;
		end
		if (!aborted) begin
			// last bursts may still sit in the slice or the queue
			cycles = 0;
			while ((ar_valid || cmd_valid) && cycles < TIMEOUT_CYCLES) begin
				@(negedge aclk);
				cycles++;
			end
			if (ar_valid || cmd_valid) begin
				u_check.report_problem("address slice or length queue did not drain");
				aborted = 1'b1;
			end
		end
		@(posedge aclk);
		u_check.end_test();
	endtask

	initial begin : main
		int          fd;
		int          n;
		int          count;
		int          maxlen;
		int          total;
		int          tests;
		string       line;
		string       name;
		logic [31:0] addr;
		aresetn      <= 1'b0;
		start        <= 1'b0;
		param_addr   <= '0;
		param_count  <= '0;
		param_maxlen <= '0;
		tests = 0;
		repeat (5) @(posedge aclk);
		aresetn <= 1'b1;
		fd = $fopen("dma_addr_trace.txt", "r");
		if (fd == 0) begin
			u_check.report_problem("cannot open dma_addr_trace.txt");
		end else begin
			while (!$feof(fd) && !aborted) begin
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin
					if ($sscanf(line, "%s %h %d %d %d", name, addr, count, maxlen,
							total) == 5) begin
						tests++;
						run_transfer(name, addr, dma_addr_pkg::count_t'(count),
							dma_addr_pkg::len_t'(maxlen), total);
					end
				end
			end
			$fclose(fd);
			if (tests == 0) begin
				u_check.report_problem("no test lines found in the trace");
			end
		end
		u_check.print_summary();
		if (u_check.total_errors() == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dma_addr_trace.txt ====
# name  byte_addr(hex)  beat_count(dec)  max_len(dec)  expected_bursts(dec)
# bursts split at 4 KB pages and at max_len + 1 beats
single_beat      00001000  1     15   1
short_aligned    00000000  16    15   1
two_bursts       00000000  32    15   2
odd_count        00000100  37    15   3
max_256          00010000  256   255  1
long_max         00020000  1000  255  4
last_beat_page   00000ffc  4     15   2
near_4k          00001ff0  20    15   2
near_4k_big      00002f00  300   255  2
span_pages       00003800  1500  255  6
single_mode      00004000  8     0    8
single_mode_edge 00004ff8  5     0    5
maxlen_one       00005ff8  7     1    4
maxlen_odd       00006004  50    6    8
top_of_space     ffffff00  64    255  1
room_128         00007e00  130   63   3
page_exact       00008000  1024  255  4
fifo_fill        00009000  12    0    12
len_two          0000a000  3     255  1
boundary_last    0000bffc  1     255  1
mid_page_127     0000c010  600   127  5

// ==== dma_addr_top.f ====
+incdir+.
dma_addr_pkg.sv
burst_if.sv
dma_param_latch.sv
dma_burst_split.sv
dma_cmd_issue.sv
dma_addr_top.sv
tb_dma_checker.sv
tb_dma_addr.sv

// ==== Makefile ====
# Verilator build and run of the DMA address generator testbench

SIM  := obj_dir/Vtb_dma_addr
SRCS := dma_addr_cfg.svh dma_addr_pkg.sv burst_if.sv dma_param_latch.sv \
	dma_burst_split.sv dma_cmd_issue.sv dma_addr_top.sv tb_dma_checker.sv tb_dma_addr.sv

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" sim.log || (echo "simulation ended early"; exit 1)

$(SIM): dma_addr_top.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_dma_addr -f dma_addr_top.f

clean:
	rm -rf obj_dir sim.log
